/* mips_fetch.f */
+incdir+design
design/fetch_pkg.sv
design/pc_sequencer.sv
design/instr_mem.sv
design/fetch_latch.sv
design/instr_fetch.sv
tb/fetch_clock_gen.sv
tb/instr_fetch_sva.sv
tb/instr_fetch_tb.sv

/* Makefile */
TOP := instr_fetch_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f mips_fetch.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* tb/instr_fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module instr_fetch_tb;
	import fetch_pkg::*;

	localparam int HALT_ADDR = 'h700;
	localparam int RUN_CYCLES = 40;
	localparam int WAIT_LIMIT = 64;

	logic clk;
	logic reset;
	redirect_t redirect;
	logic stall;
	load_t load;
	ifid_t ifid;
	logic [`FETCH_WORD_W-1:0] pc;
	logic halted;

	// Every word written through the loader
	logic [`FETCH_WORD_W-1:0] program_words [0:`FETCH_MEM_DEPTH-1];
	logic [`FETCH_WORD_W-1:0] word;
	logic [`FETCH_WORD_W-1:0] pc_before;
	ifid_t ifid_before;
	logic halt_in_slot;
	integer seed;
	int target;
	int cycles;
	int errors;
	int tests_passed;
	int tests_failed;
	// Assertion failures already charged to earlier tests
	int sva_charged;

	assign halt_in_slot = ifid.valid && (ifid.instruction == `FETCH_HALT_WORD);

	fetch_clock_gen clock_i (.clk(clk), .reset(reset));

	instr_fetch dut_i (
		.clk(clk), .reset(reset), .redirect(redirect), .stall(stall),
		.load(load), .ifid(ifid), .pc(pc), .halted(halted)
	);

	bind instr_fetch instr_fetch_sva sva_i (
		.clk(clk), .reset(reset), .redirect(redirect), .stall(stall),
		.load(load), .ifid(ifid), .pc(pc), .halted(halted)
	);

	task automatic check_word(input string name, input logic [31:0] expected, actual);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		errors += dut_i.sva_i.failures - sva_charged;
		sva_charged = dut_i.sva_i.failures;
		if (errors == 0)
		begin
			tests_passed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors);
		end
		errors = 0;
	endtask

	// One cycle of request, then back to sequential
	task automatic apply_redirect(input pc_src_e src, input int jump_to);
		redirect = '{src: src, branch_target: 'h120, jump_target: jump_to, reg_target: 'h360};
		@(negedge clk);
		redirect.src = PC_SEQ;
	endtask

	initial
	begin
		seed = 80;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		sva_charged = 0;
		redirect = '0;
		stall = 1'b0;
		// Debug from the start keeps pc at 0 until the program is in
		load = '0;
		load.debug = 1'b1;

		//////////////////////////////////////////////////////////////////
		// Reset state
		//////////////////////////////////////////////////////////////////
		cycles = 0;
		while (reset !== 1'b0 && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (reset !== 1'b0)
		begin
			$display("Timeout waiting for reset to be released");
			errors++;
		end
		check_word("pc", 0, pc);
		check_word("ifid.valid", 0, 32'(ifid.valid));
		check_word("halted", 0, 32'(halted));
		finish_test("reset_state");

		//////////////////////////////////////////////////////////////////
		// Load the whole memory, then run from 0
		//////////////////////////////////////////////////////////////////
		for (int addr_i = 0; addr_i < `FETCH_MEM_DEPTH; addr_i++)
		begin
			word = $random(seed);
			while (word == `FETCH_HALT_WORD)
			begin
				word = $random(seed);
			end
			if (addr_i == HALT_ADDR)
			begin
				word = `FETCH_HALT_WORD;
			end
			load.write = 1'b1;
			load.addr = addr_i;
			load.data = word;
			program_words[addr_i] = word;
			@(negedge clk);
		end
		load = '0;
		repeat (RUN_CYCLES) @(negedge clk);
		check_word("pc", RUN_CYCLES, pc);
		check_word("ifid.pc_next", RUN_CYCLES, ifid.pc_next);
		check_word("ifid.instruction", program_words[RUN_CYCLES-1], ifid.instruction);
		finish_test("load_and_run");

		//////////////////////////////////////////////////////////////////
		// Branch, jump and register redirects
		//////////////////////////////////////////////////////////////////
		for (int s = 1; s < 4; s++)
		begin
			target = 'h120 * s;
			apply_redirect(pc_src_e'(s), 'h240);
			check_word("pc", target, pc);
			check_word("ifid.instruction", 0, ifid.instruction);
			check_word("ifid.valid", 0, 32'(ifid.valid));
			@(negedge clk);
			check_word("ifid.instruction", program_words[target], ifid.instruction);
			check_word("ifid.pc_next", target + 1, ifid.pc_next);
			repeat (2) @(negedge clk);
		end
		finish_test("redirect");

		//////////////////////////////////////////////////////////////////
		// Stall with an ignored redirect, then debug with a write
		//////////////////////////////////////////////////////////////////
		pc_before = pc;
		ifid_before = ifid;
		stall = 1'b1;
		apply_redirect(PC_BRANCH, 'h240);
		repeat (3) @(negedge clk);
		stall = 1'b0;
		// New word lands on the path of the halt run below
		load = '{debug: 1'b1, write: 1'b1, addr: HALT_ADDR - 2, data: $random(seed)};
		program_words[HALT_ADDR - 2] = load.data;
		@(negedge clk);
		load.write = 1'b0;
		repeat (2) @(negedge clk);
		check_word("pc", pc_before, pc);
		check_word("ifid.instruction", ifid_before.instruction, ifid.instruction);
		check_word("ifid.pc_next", ifid_before.pc_next, ifid.pc_next);
		load.debug = 1'b0;
		finish_test("stall_and_debug_hold");

		//////////////////////////////////////////////////////////////////
		// Halt word, then redirects that must be ignored
		//////////////////////////////////////////////////////////////////
		apply_redirect(PC_JUMP, HALT_ADDR - 3);
		cycles = 0;
		while (!halt_in_slot && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halt_in_slot)
		begin
			$display("Timeout waiting for the halt word to reach IF/ID");
			errors++;
		end
		@(negedge clk);
		check_word("halted", 1, 32'(halted));
		pc_before = pc;
		ifid_before = ifid;
		apply_redirect(PC_JUMP, 'h10);
		apply_redirect(PC_REG, 'h10);
		repeat (2) @(negedge clk);
		check_word("pc", pc_before, pc);
		check_word("ifid.instruction", ifid_before.instruction, ifid.instruction);
		check_word("ifid.pc_next", ifid_before.pc_next, ifid.pc_next);
		finish_test("halt");

		$display("Tests ok: %0d, tests with errors: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* tb/instr_fetch_sva.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module instr_fetch_sva
(
	input logic                     clk,
	input logic                     reset,
	input fetch_pkg::redirect_t     redirect,
	input logic                     stall,
	input fetch_pkg::load_t         load,
	input fetch_pkg::ifid_t         ifid,
	input logic [`FETCH_WORD_W-1:0] pc,
	input logic                     halted
);
	import fetch_pkg::*;

	// Copy of program memory, fed by the loader port
	logic [`FETCH_WORD_W-1:0] shadow [0:`FETCH_MEM_DEPTH-1];
	logic [`FETCH_WORD_W-1:0] fetched_addr;
	logic [`FETCH_WORD_W-1:0] expected_word;
	logic [`FETCH_WORD_W-1:0] expected_target;
	logic frozen;
	logic redirect_taken;
	logic seq_step;
	// Number of failed fetch rules so far
	int failures = 0;

	always_ff @(posedge clk)
	begin
		if (load.debug && load.write)
		begin
			shadow[load.addr[`FETCH_ADDR_W-1:0]] <= load.data;
		end
	end

	// Slot word came from one below its return address
	assign fetched_addr = ifid.pc_next - 1;
	assign expected_word = shadow[fetched_addr[`FETCH_ADDR_W-1:0]];

	// Debug, halt and stall all freeze the stage
	assign frozen = load.debug | halted | stall;
	assign redirect_taken = ~frozen & (redirect.src != PC_SEQ);
	assign seq_step = ~frozen & (redirect.src == PC_SEQ);

	always_comb
	begin
		case (redirect.src)
			PC_BRANCH: expected_target = redirect.branch_target;
			PC_JUMP:   expected_target = redirect.jump_target;
			default:   expected_target = redirect.reg_target;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch rules
	//////////////////////////////////////////////////////////////////////

	reset_state: assert property (@(posedge clk)
		reset |=> (pc == '0 && ifid == '0 && !halted))
		else
		begin
			failures++;
			$error("State not cleared by reset");
		end

	fetch_data: assert property (@(posedge clk) disable iff (reset)
		ifid.valid |-> ifid.instruction == expected_word)
		else
		begin
			failures++;
			$error("IF/ID instruction differs from the loaded word");
		end

	sequential_pc: assert property (@(posedge clk) disable iff (reset)
		seq_step |=> pc == $past(pc) + 1)
		else
		begin
			failures++;
			$error("PC did not step by one");
		end

	redirect_pc: assert property (@(posedge clk) disable iff (reset)
		redirect_taken |=> (pc == $past(expected_target) && ifid == '0))
		else
		begin
			failures++;
			$error("Redirect target or flush wrong");
		end

	hold_state: assert property (@(posedge clk) disable iff (reset)
		(stall || load.debug) |=> ($stable(pc) && $stable(ifid)))
		else
		begin
			failures++;
			$error("State moved during stall or debug");
		end

	// Halt flag rises one edge after the halt word shows up
	halt_rise: assert property (@(posedge clk) disable iff (reset)
		(ifid.valid && ifid.instruction == `FETCH_HALT_WORD) |=> halted)
		else
		begin
			failures++;
			$error("Halted did not rise after the halt word");
		end

	halt_sticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> (halted && $stable(pc) && $stable(ifid)))
		else
		begin
			failures++;
			$error("Stage moved while halted");
		end

endmodule

/* tb/fetch_clock_gen.sv */
`timescale 1ns/1ns

module fetch_clock_gen
(
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Two rising edges in reset, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* design/instr_fetch.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module instr_fetch
(
	input  logic                     clk,
	input  logic                     reset,
	input  fetch_pkg::redirect_t     redirect,
	input  logic                     stall,
	input  fetch_pkg::load_t         load,
	output fetch_pkg::ifid_t         ifid,
	output logic [`FETCH_WORD_W-1:0] pc,
	output logic                     halted
);

	// Sequential address for the IF/ID record
	logic [`FETCH_WORD_W-1:0] pc_plus1;
	// Memory output to the latch
	logic [`FETCH_WORD_W-1:0] instruction;
	// Capture and clear strobes from the sequencer
	logic flush;
	logic advance;

	//////////////////////////////////////////////////////////////////////
	// Address side
	//////////////////////////////////////////////////////////////////////

	// IF/ID fed back for halt detection
	pc_sequencer seq_i (
		.clk      (clk),
		.reset    (reset),
		.redirect (redirect),
		.stall    (stall),
		.debug    (load.debug),
		.ifid     (ifid),
		.pc       (pc),
		.pc_plus1 (pc_plus1),
		.flush    (flush),
		.advance  (advance),
		.halted   (halted)
	);

	//////////////////////////////////////////////////////////////////////
	// Memory and IF/ID register
	//////////////////////////////////////////////////////////////////////

	instr_mem mem_i (
		.clk         (clk),
		.reset       (reset),
		.pc          (pc),
		.load        (load),
		.advance     (advance),
		.flush       (flush),
		.instruction (instruction)
	);

	fetch_latch latch_i (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.pc_plus1    (pc_plus1),
		.advance     (advance),
		.flush       (flush),
		.ifid        (ifid)
	);

endmodule

/* design/fetch_latch.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_latch
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`FETCH_WORD_W-1:0] instruction,
	input  logic [`FETCH_WORD_W-1:0] pc_plus1,
	input  logic                     advance,
	input  logic                     flush,
	output fetch_pkg::ifid_t         ifid
);

	// Return address of the fetched word
	logic [`FETCH_WORD_W-1:0] pc_next_q;
	// Slot holds a real instruction
	logic valid_q;

	//////////////////////////////////////////////////////////////////////
	// IF/ID side registers
	//////////////////////////////////////////////////////////////////////

	// Same enables as the memory output register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc_next_q <= '0;
			valid_q <= 1'b0;
		end
		else if (flush)
		begin
			// Bubble after a taken redirect
			pc_next_q <= '0;
			valid_q <= 1'b0;
		end
		else if (advance)
		begin
			pc_next_q <= pc_plus1;
			valid_q <= 1'b1;
		end
	end

	// Instruction already registered inside the memory
	assign ifid = '{
		instruction: instruction,
		pc_next:     pc_next_q,
		valid:       valid_q
	};

endmodule

/* design/instr_mem.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module instr_mem
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`FETCH_WORD_W-1:0] pc,
	input  fetch_pkg::load_t         load,
	input  logic                     advance,
	input  logic                     flush,
	output logic [`FETCH_WORD_W-1:0] instruction
);

	// Program storage
	logic [`FETCH_WORD_W-1:0] mem [0:`FETCH_MEM_DEPTH-1];

	// Read index from the low PC bits
	logic [`FETCH_ADDR_W-1:0] rd_index;
	// Write index from the low loader address bits
	logic [`FETCH_ADDR_W-1:0] wr_index;
	// Loader write enable
	logic wr_en;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	// Upper PC bits ignored, memory wraps
	assign rd_index = pc[`FETCH_ADDR_W-1:0];
	assign wr_index = load.addr[`FETCH_ADDR_W-1:0];

	// Writes only while debug holds the stage
	assign wr_en = load.debug & load.write;

	//////////////////////////////////////////////////////////////////////
	// Debug write port
	//////////////////////////////////////////////////////////////////////

	// Array contents survive reset
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_index] <= load.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port and output register
	//////////////////////////////////////////////////////////////////////

	// Flush gives a zero NOP, no advance means hold
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instruction <= '0;
		end
		else if (flush)
		begin
			instruction <= '0;
		end
		else if (advance)
		begin
			// Debug never overlaps a read, advance is low then
			instruction <= mem[rd_index];
		end
	end

endmodule

/* design/pc_sequencer.sv */
`timescale 1ns/1ns
`include "fetch_consts.svh"

module pc_sequencer
(
	input  logic                     clk,
	input  logic                     reset,
	input  fetch_pkg::redirect_t     redirect,
	input  logic                     stall,
	input  logic                     debug,
	input  fetch_pkg::ifid_t         ifid,
	output logic [`FETCH_WORD_W-1:0] pc,
	output logic [`FETCH_WORD_W-1:0] pc_plus1,
	output logic                     flush,
	output logic                     advance,
	output logic                     halted
);
	import fetch_pkg::*;

	// Selected next address
	logic [`FETCH_WORD_W-1:0] pc_target;
	// Redirect requested this cycle
	logic taken;
	// Whole stage frozen
	logic hold;
	// Halt word sitting in IF/ID
	logic halt_seen;

	//////////////////////////////////////////////////////////////////////
	// Address arithmetic
	//////////////////////////////////////////////////////////////////////

	// Word addressed, so the next sequential PC is plus one
	assign pc_plus1 = pc + `FETCH_WORD_W'(1);

	// Any source other than sequential counts as taken
	assign taken = (redirect.src != PC_SEQ);

	// Next address mux
	always_comb
	begin
		case (redirect.src)
			PC_BRANCH: pc_target = redirect.branch_target;
			PC_JUMP:   pc_target = redirect.jump_target;
			PC_REG:    pc_target = redirect.reg_target;
			default:   pc_target = pc_plus1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Priority: debug, halted, stall, redirect, advance
	//////////////////////////////////////////////////////////////////////

	// Top three priorities all freeze everything
	assign hold = debug | halted | stall;

	// Redirect flushes the fetched slot
	assign flush = ~hold & taken;

	// Plain sequential capture
	assign advance = ~hold & ~taken;

	//////////////////////////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////////////////////////

	// Redirect target or pc+1, both come through the mux
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
		end
		else if (!hold)
		begin
			pc <= pc_target;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sticky halt
	//////////////////////////////////////////////////////////////////////

	// Whole word compare, only a valid slot counts
	assign halt_seen = ifid.valid && (ifid.instruction == `FETCH_HALT_WORD);

	// Stays set until reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			halted <= 1'b0;
		end
		else if (halt_seen)
		begin
			halted <= 1'b1;
		end
	end

endmodule

/* design/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// Next address source
	//////////////////////////////////////////////////////////////////////

	// PC_SEQ means no redirect, the others are taken
	typedef enum logic [1:0]
	{
		PC_SEQ    = 2'd0,
		PC_BRANCH = 2'd1,
		PC_JUMP   = 2'd2,
		PC_REG    = 2'd3
	} pc_src_e;

	// Redirect request from the later stages
	typedef struct packed
	{
		pc_src_e                  src;
		logic [`FETCH_WORD_W-1:0] branch_target;
		logic [`FETCH_WORD_W-1:0] jump_target;
		logic [`FETCH_WORD_W-1:0] reg_target;
	} redirect_t;

	//////////////////////////////////////////////////////////////////////
	// Debug loader and IF/ID record
	//////////////////////////////////////////////////////////////////////

	// Level debug freezes the stage, write is a one-cycle strobe
	typedef struct packed
	{
		logic                     debug;
		logic                     write;
		logic [`FETCH_WORD_W-1:0] addr;
		logic [`FETCH_WORD_W-1:0] data;
	} load_t;

	// Record handed to decode
	typedef struct packed
	{
		logic [`FETCH_WORD_W-1:0] instruction;
		logic [`FETCH_WORD_W-1:0] pc_next;
		logic                     valid;
	} ifid_t;

endpackage

/* design/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Instruction word and PC width
`define FETCH_WORD_W 32

// Instruction memory size in words
`define FETCH_MEM_DEPTH 2048

// Memory index width, taken from the low PC bits
`define FETCH_ADDR_W 11

// All-ones word marks the end of a program
`define FETCH_HALT_WORD 32'hFFFF_FFFF

`endif
